/* bpm_digits.sv */
`timescale 1ns/1ps
`default_nettype none

module bpm_digits (
    input  logic                     clk_100mhz,
    input  logic                     rst_n,
    input  logic [7:0]               bpm,
    output hr_display_pkg::bpm_bcd_t digits
);

    // bcd digits above, binary shifted in below
    logic [19:0] shift;

    // double dabble, eight shift steps
    always_comb begin
        shift = {12'd0, bpm};
        for (int i = 0; i < 8; i++) begin
            if (shift[11:8] >= 4'd5) shift[11:8] = shift[11:8] + 4'd3;
            if (shift[15:12] >= 4'd5) shift[15:12] = shift[15:12] + 4'd3;
            if (shift[19:16] >= 4'd5) shift[19:16] = shift[19:16] + 4'd3;
            shift = shift << 1;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (!rst_n) begin
            digits <= '0;
        end else begin
            digits.hundreds <= shift[19:16];
            digits.tens <= shift[15:12];
            digits.ones <= shift[11:8];
        end
    end

endmodule

`default_nettype wire

/* hr_display.f */
+incdir+.
hr_display_pkg.sv
status_decode.sv
bpm_digits.sv
sprite_addr_gen.sv
shape_overlay.sv
pixel_mixer.sv
hr_display.sv
hr_display_assertions.sv
hr_display_tb.sv

/* hr_display.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hr_display_params.svh"

module hr_display (
    input  logic                        clk_100mhz,
    input  logic                        rst_n,
    input  logic [`HR_HCOUNT_W-1:0]     hcount,
    input  logic [`HR_VCOUNT_W-1:0]     vcount,
    input  logic [7:0]                  bpm,
    input  hr_display_pkg::sys_status_t status,
    input  logic                        sprite_rom_data,
    output logic [`HR_ROM_ADDR_W-1:0]   sprite_rom_addr,
    output hr_display_pkg::color_u      rgb
);
    import hr_display_pkg::*;

    overlay_ctrl_t ovl;
    sprite_en_t    spr_en;
    bpm_bcd_t      digits;
    sprite_pix_t   spr;
    color_u        ovl_pix;

    // control path
    status_decode status_decode_i (.*);
    bpm_digits bpm_digits_i (.*);

    // pixel path, three stages
    sprite_addr_gen sprite_addr_gen_i (.*, .rom_addr(sprite_rom_addr));
    shape_overlay shape_overlay_i (.*);
    pixel_mixer pixel_mixer_i (.*, .rom_data(sprite_rom_data));

endmodule

`default_nettype wire

/* hr_display_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hr_display_params.svh"

module hr_display_assertions (
    input logic                          clk_100mhz,
    input logic                          rst_n,
    input hr_display_pkg::color_u        rgb,
    input logic [`HR_ROM_ADDR_W-1:0]     sprite_rom_addr,
    input hr_display_pkg::overlay_ctrl_t ovl
);

    // output register cleared by a reset cycle
    rgb_cleared: assert property (@(posedge clk_100mhz) !rst_n |=> rgb.raw == '0)
        else $error("rgb is not zero in the cycle after reset");

    // address stays inside the sprite sheet
    addr_in_sheet: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        sprite_rom_addr < `HR_SHEET_W * `HR_SHEET_H)
        else $error("sprite_rom_addr points past the end of the sprite sheet");

    progress_bounded: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        ovl.progress_w <= `HR_PROGRESS_MAX)
        else $error("progress width is above its maximum");

endmodule

bind hr_display hr_display_assertions hr_display_assertions_i (
    .clk_100mhz      (clk_100mhz),
    .rst_n           (rst_n),
    .rgb             (rgb),
    .sprite_rom_addr (sprite_rom_addr),
    .ovl             (ovl)
);

`default_nettype wire

/* hr_display_params.svh */
`ifndef HR_DISPLAY_PARAMS_SVH
`define HR_DISPLAY_PARAMS_SVH

// raster and counters
`define HR_SCREEN_W 1024
`define HR_SCREEN_H 768
`define HR_HCOUNT_W 11
`define HR_VCOUNT_W 10

// sprite sheet, one bit per pixel
`define HR_SHEET_W 610
`define HR_SHEET_H 356
`define HR_ROM_ADDR_W 18

//////////////////////////////////////////////////////////////////////
// rectangle overlays
//////////////////////////////////////////////////////////////////////
`define HR_TOP_BAR_X 700
`define HR_TOP_BAR_Y 0
`define HR_TOP_BAR_W 250
`define HR_TOP_BAR_H 100
`define HR_BOTTOM_BAR_X 0
`define HR_BOTTOM_BAR_Y (`HR_SCREEN_H - 100)
`define HR_BOTTOM_BAR_W `HR_SCREEN_W
`define HR_BOTTOM_BAR_H 100
`define HR_ERROR_BOX_X 162
`define HR_ERROR_BOX_Y 234
`define HR_ERROR_BOX_W 700
`define HR_ERROR_BOX_H 300
// progress width is live
`define HR_PROGRESS_X 0
`define HR_PROGRESS_Y 374
`define HR_PROGRESS_H 20

//////////////////////////////////////////////////////////////////////
// sprites, screen position and sheet rectangle
//////////////////////////////////////////////////////////////////////
`define HR_LOGO_X 10
`define HR_LOGO_Y 20
`define HR_LOGO_SX 0
`define HR_LOGO_SY 223
`define HR_LOGO_SW 143
`define HR_LOGO_SH 132
`define HR_COLLECT_X 624
`define HR_COLLECT_Y 678
`define HR_COLLECT_SX 251
`define HR_COLLECT_SY 61
`define HR_COLLECT_SW 359
`define HR_COLLECT_SH 73
`define HR_BPM_LABEL_X 785
`define HR_BPM_LABEL_Y 110
`define HR_BPM_LABEL_SX 178
`define HR_BPM_LABEL_SY 229
`define HR_BPM_LABEL_SW 67
`define HR_BPM_LABEL_SH 36
`define HR_TITLE_X 168
`define HR_TITLE_Y 70
`define HR_TITLE_SX 261
`define HR_TITLE_SY 0
`define HR_TITLE_SW 319
`define HR_TITLE_SH 61
`define HR_ERROR_TXT_X 540
`define HR_ERROR_TXT_Y 350
`define HR_ERROR_TXT_SX 437
`define HR_ERROR_TXT_SY 134
`define HR_ERROR_TXT_SW 139
`define HR_ERROR_TXT_SH 61
`define HR_PAUSED_TXT_X 624
`define HR_PAUSED_TXT_Y 683
`define HR_PAUSED_TXT_SX 251
`define HR_PAUSED_TXT_SY 134
`define HR_PAUSED_TXT_SW 186
`define HR_PAUSED_TXT_SH 71
`define HR_BOOT_TXT_X 400
`define HR_BOOT_TXT_Y 200
`define HR_BOOT_TXT_SX 251
`define HR_BOOT_TXT_SY 205
`define HR_BOOT_TXT_SW 212
`define HR_BOOT_TXT_SH 76

// digit glyphs 0..9 side by side on one sheet row
`define HR_DIGIT_SX0 144
`define HR_DIGIT_SY 281
`define HR_DIGIT_PITCH 46
`define HR_DIGIT_W 40
`define HR_DIGIT_H 74
`define HR_HUNDREDS_X 740
`define HR_HUNDREDS_Y 20
`define HR_TENS_X 786
`define HR_TENS_Y 20
`define HR_ONES_X 832
`define HR_ONES_Y 20

// colors, 4 bits per channel
`define HR_COLOR_GREY 12'h666
`define HR_COLOR_WHITE 12'hfff
`define HR_COLOR_RED 12'hf00
`define HR_COLOR_BLUE 12'h17a
`define HR_COLOR_ALERT 12'hf22

// boot bar and pipeline
`define HR_PROGRESS_DIV_W 4
`define HR_PROGRESS_MAX 1024
`define HR_PIPE_LAT 3

`endif

/* hr_display_pkg.sv */
`default_nettype none

`include "hr_display_params.svh"

package hr_display_pkg;

    typedef enum logic [1:0] {
        st_paused,
        st_running,
        st_error,
        st_boot
    } sys_status_t;

    // one color word, seen raw or per channel
    typedef union packed {
        logic [11:0] raw;
        struct packed {
            logic [3:0] r;
            logic [3:0] g;
            logic [3:0] b;
        } rgb;
    } color_u;

    typedef struct packed {
        logic top_en;
        logic bottom_en;
        logic error_en;
        logic progress_en;
        color_u top_color;
        color_u bottom_color;
        color_u error_color;
        logic [`HR_HCOUNT_W-1:0] progress_w;
    } overlay_ctrl_t;

    typedef struct packed {
        logic logo;
        logic collecting;
        logic hundreds;
        logic bpm_label;
        logic tens;
        logic ones;
        logic title;
        logic error_txt;
        logic paused_txt;
        logic boot_txt;
    } sprite_en_t;

    typedef struct packed {
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] ones;
    } bpm_bcd_t;

    typedef struct packed {
        logic hit;
        color_u color;
    } sprite_pix_t;

    // half-open rectangle test
    function automatic logic in_rect(input int px, input int py, input int x0,
                                     input int y0, input int w, input int h);
        return (px >= x0) && (px < x0 + w) && (py >= y0) && (py < y0 + h);
    endfunction

endpackage

`default_nettype wire

/* hr_display_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hr_display_params.svh"

module hr_display_tb;
    import hr_display_pkg::*;

    typedef struct {
        int                        born;
        logic                      valid;
        logic [`HR_ROM_ADDR_W-1:0] addr;
        color_u                    rgb;
    } pred_t;

    logic                          clk_100mhz;
    logic                          rst_n;
    logic [`HR_HCOUNT_W-1:0]       hcount;
    logic [`HR_VCOUNT_W-1:0]       vcount;
    logic [7:0]                    bpm;
    sys_status_t                   status;
    logic                          sprite_rom_data = 1'b0;
    logic [`HR_ROM_ADDR_W-1:0]     sprite_rom_addr;
    color_u                        rgb;

    // model copies of the control registers
    overlay_ctrl_t                 m_ovl;
    sprite_en_t                    m_en;
    bpm_bcd_t                      m_digits;
    logic [`HR_PROGRESS_DIV_W-1:0] m_presc;

    pred_t addr_q[$];
    pred_t rgb_q[$];
    int    cyc;
    int    hold;

    // sweep origins just left of each sprite and one on the boot bar rows
    int sweep_x [0:10] = '{`HR_LOGO_X - 4, `HR_COLLECT_X - 4, `HR_HUNDREDS_X - 4,
                           `HR_BPM_LABEL_X - 4, `HR_TENS_X - 4, `HR_ONES_X - 4,
                           `HR_TITLE_X - 4, `HR_ERROR_TXT_X - 4, `HR_PAUSED_TXT_X - 4,
                           `HR_BOOT_TXT_X - 4, `HR_PROGRESS_X};
    int sweep_y [0:10] = '{`HR_LOGO_Y, `HR_COLLECT_Y, `HR_HUNDREDS_Y,
                           `HR_BPM_LABEL_Y, `HR_TENS_Y + 20, `HR_ONES_Y + 40,
                           `HR_TITLE_Y, `HR_ERROR_TXT_Y, `HR_PAUSED_TXT_Y,
                           `HR_BOOT_TXT_Y, `HR_PROGRESS_Y + 4};

    hr_display hr_display_i (.*);

    initial begin
        clk_100mhz = 1'b0;
        forever begin
            #5 clk_100mhz = ~clk_100mhz;
        end
    end

    // registered sprite sheet holding the parity of the address
    always @(posedge clk_100mhz) begin
        sprite_rom_data <= ^sprite_rom_addr;
    end

    //////////////////////////////////////////////////////////////////////
    // reporting
    //////////////////////////////////////////////////////////////////////
    task automatic stop_run();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rgb(input color_u got, input color_u exp);
        if (got !== exp) begin
            $display("error at %0t ns: rgb is %03h, expected %03h", $time, got.raw, exp.raw);
            stop_run();
        end
    endtask

    task automatic check_addr(input logic [`HR_ROM_ADDR_W-1:0] got,
                              input logic [`HR_ROM_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: sprite_rom_addr is %0d, expected %0d", $time, got, exp);
            stop_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    function automatic logic in_box(input int px, input int py, input int x0, input int y0,
                                    input int w, input int h);
        return px >= x0 && px < x0 + w && py >= y0 && py < y0 + h;
    endfunction

    function automatic color_u overlay_color(input int px, input int py,
                                             input overlay_ctrl_t o);
        color_u c;
        c.raw = '0;
        if (o.top_en && in_box(px, py, `HR_TOP_BAR_X, `HR_TOP_BAR_Y,
                               `HR_TOP_BAR_W, `HR_TOP_BAR_H)) begin
            c.raw = c.raw | o.top_color.raw;
        end
        if (o.bottom_en && in_box(px, py, `HR_BOTTOM_BAR_X, `HR_BOTTOM_BAR_Y,
                                  `HR_BOTTOM_BAR_W, `HR_BOTTOM_BAR_H)) begin
            c.raw = c.raw | o.bottom_color.raw;
        end
        if (o.error_en && in_box(px, py, `HR_ERROR_BOX_X, `HR_ERROR_BOX_Y,
                                 `HR_ERROR_BOX_W, `HR_ERROR_BOX_H)) begin
            c.raw = c.raw | o.error_color.raw;
        end
        if (o.progress_en && in_box(px, py, `HR_PROGRESS_X, `HR_PROGRESS_Y,
                                    int'(o.progress_w), `HR_PROGRESS_H)) begin
            c.raw = c.raw | `HR_COLOR_WHITE;
        end
        return c;
    endfunction

    // first enabled sprite under the pixel wins
    function automatic void try_sprite(input logic en, input int px, input int py,
                                       input int x0, input int y0, input int sx, input int sy,
                                       input int w, input int h, input logic red,
                                       inout logic found,
                                       inout logic [`HR_ROM_ADDR_W-1:0] addr,
                                       inout color_u col);
        if (!found && en && in_box(px, py, x0, y0, w, h)) begin
            found = 1'b1;
            addr = `HR_ROM_ADDR_W'((sy + py - y0) * `HR_SHEET_W + sx + px - x0);
            col.raw = red ? `HR_COLOR_RED : `HR_COLOR_WHITE;
        end
    endfunction

    function automatic pred_t predict_pixel(input int px, input int py);
        pred_t                     p;
        logic                      found;
        logic [`HR_ROM_ADDR_W-1:0] addr;
        color_u                    col;
        int                        hsx;
        int                        tsx;
        int                        osx;
        found = 1'b0;
        addr = '0;
        col.raw = '0;
        hsx = `HR_DIGIT_SX0 + int'(m_digits.hundreds) * `HR_DIGIT_PITCH;
        tsx = `HR_DIGIT_SX0 + int'(m_digits.tens) * `HR_DIGIT_PITCH;
        osx = `HR_DIGIT_SX0 + int'(m_digits.ones) * `HR_DIGIT_PITCH;
        try_sprite(m_en.logo, px, py, `HR_LOGO_X, `HR_LOGO_Y, `HR_LOGO_SX, `HR_LOGO_SY,
                   `HR_LOGO_SW, `HR_LOGO_SH, 1'b1, found, addr, col);
        try_sprite(m_en.collecting, px, py, `HR_COLLECT_X, `HR_COLLECT_Y, `HR_COLLECT_SX,
                   `HR_COLLECT_SY, `HR_COLLECT_SW, `HR_COLLECT_SH, 1'b0, found, addr, col);
        try_sprite(m_en.hundreds, px, py, `HR_HUNDREDS_X, `HR_HUNDREDS_Y, hsx, `HR_DIGIT_SY,
                   `HR_DIGIT_W, `HR_DIGIT_H, 1'b0, found, addr, col);
        try_sprite(m_en.bpm_label, px, py, `HR_BPM_LABEL_X, `HR_BPM_LABEL_Y,
                   `HR_BPM_LABEL_SX, `HR_BPM_LABEL_SY, `HR_BPM_LABEL_SW, `HR_BPM_LABEL_SH,
                   1'b1, found, addr, col);
        try_sprite(m_en.tens, px, py, `HR_TENS_X, `HR_TENS_Y, tsx, `HR_DIGIT_SY,
                   `HR_DIGIT_W, `HR_DIGIT_H, 1'b0, found, addr, col);
        try_sprite(m_en.ones, px, py, `HR_ONES_X, `HR_ONES_Y, osx, `HR_DIGIT_SY,
                   `HR_DIGIT_W, `HR_DIGIT_H, 1'b0, found, addr, col);
        try_sprite(m_en.title, px, py, `HR_TITLE_X, `HR_TITLE_Y, `HR_TITLE_SX, `HR_TITLE_SY,
                   `HR_TITLE_SW, `HR_TITLE_SH, 1'b1, found, addr, col);
        try_sprite(m_en.error_txt, px, py, `HR_ERROR_TXT_X, `HR_ERROR_TXT_Y,
                   `HR_ERROR_TXT_SX, `HR_ERROR_TXT_SY, `HR_ERROR_TXT_SW, `HR_ERROR_TXT_SH,
                   1'b0, found, addr, col);
        try_sprite(m_en.paused_txt, px, py, `HR_PAUSED_TXT_X, `HR_PAUSED_TXT_Y,
                   `HR_PAUSED_TXT_SX, `HR_PAUSED_TXT_SY, `HR_PAUSED_TXT_SW,
                   `HR_PAUSED_TXT_SH, 1'b0, found, addr, col);
        try_sprite(m_en.boot_txt, px, py, `HR_BOOT_TXT_X, `HR_BOOT_TXT_Y, `HR_BOOT_TXT_SX,
                   `HR_BOOT_TXT_SY, `HR_BOOT_TXT_SW, `HR_BOOT_TXT_SH, 1'b0, found, addr, col);
        p.born = 0;
        p.valid = 1'b0;
        p.addr = addr;
        // sheet bit of the modelled ROM decides sprite or overlay
        if (found && (^addr)) begin
            p.rgb = col;
        end else begin
            p.rgb = overlay_color(px, py, m_ovl);
        end
        return p;
    endfunction

    // control registers after the next rising edge
    task automatic update_ctrl(input sys_status_t st, input logic [7:0] b);
        overlay_ctrl_t                 o;
        sprite_en_t                    e;
        logic [`HR_PROGRESS_DIV_W-1:0] pr;
        o = '0;
        e = '0;
        pr = '0;
        e.logo = 1'b1;
        e.title = 1'b1;
        case (st)
            st_paused: begin
                o.top_en = 1'b1;
                o.bottom_en = 1'b1;
                o.top_color.raw = `HR_COLOR_GREY;
                o.bottom_color.raw = `HR_COLOR_GREY;
                e.paused_txt = 1'b1;
                e.bpm_label = 1'b1;
                e.tens = 1'b1;
                e.ones = 1'b1;
            end
            st_running: begin
                o.top_en = 1'b1;
                o.bottom_en = 1'b1;
                o.top_color.raw = `HR_COLOR_RED;
                o.bottom_color.raw = `HR_COLOR_BLUE;
                e.collecting = 1'b1;
                e.bpm_label = 1'b1;
                e.tens = 1'b1;
                e.ones = 1'b1;
                e.hundreds = (b >= 8'd100);
            end
            st_error: begin
                o.top_en = 1'b1;
                o.bottom_en = 1'b1;
                o.error_en = 1'b1;
                o.top_color.raw = `HR_COLOR_GREY;
                o.bottom_color.raw = `HR_COLOR_GREY;
                o.error_color.raw = `HR_COLOR_ALERT;
                e.error_txt = 1'b1;
            end
            default: begin
                o.progress_en = 1'b1;
                e.boot_txt = 1'b1;
                pr = m_presc + 1'b1;
                o.progress_w = m_ovl.progress_w;
                // one pixel per 16 cycles
                if (m_presc == '0 && m_ovl.progress_w < `HR_PROGRESS_MAX) begin
                    o.progress_w = m_ovl.progress_w + 1'b1;
                end
            end
        endcase
        m_ovl = o;
        m_en = e;
        m_presc = pr;
        m_digits.hundreds = 4'(b / 100);
        m_digits.tens = 4'((b / 10) % 10);
        m_digits.ones = 4'(b % 10);
    endtask

    //////////////////////////////////////////////////////////////////////
    // one pixel per falling edge
    //////////////////////////////////////////////////////////////////////
    task automatic step(input logic push, input int px, input int py,
                        input sys_status_t st, input logic [7:0] b);
        pred_t p;
        @(negedge clk_100mhz);
        // pipeline still filling from reset shows zero
        if (addr_q.size() > 0 && addr_q[0].born == cyc - 1) begin
            p = addr_q.pop_front();
            if (p.valid) begin
                check_addr(sprite_rom_addr, p.addr);
            end
        end else if (cyc < 1) begin
            check_addr(sprite_rom_addr, '0);
        end
        if (rgb_q.size() > 0 && rgb_q[0].born == cyc - `HR_PIPE_LAT) begin
            p = rgb_q.pop_front();
            if (p.valid) begin
                check_rgb(rgb, p.rgb);
            end
        end else if (cyc < `HR_PIPE_LAT) begin
            check_rgb(rgb, '0);
        end
        rst_n = 1'b1;
        status = st;
        bpm = b;
        hcount = `HR_HCOUNT_W'(px);
        vcount = `HR_VCOUNT_W'(py);
        if (push) begin
            p = predict_pixel(px, py);
            p.born = cyc;
            p.valid = (hold == 0);
            addr_q.push_back(p);
            rgb_q.push_back(p);
        end
        update_ctrl(st, b);
        if (hold > 0) begin
            hold--;
        end
        cyc++;
    endtask

    initial begin
        sys_status_t st;
        logic [7:0]  b;
        int          px;
        int          py;
        int          org;
        int          k;
        int          wait_cnt;
        rst_n = 1'b0;
        hcount = '0;
        vcount = '0;
        bpm = '0;
        status = st_paused;
        m_ovl = '0;
        m_en = '0;
        m_digits = '0;
        m_presc = '0;
        cyc = 0;
        hold = 0;
        px = 0;
        py = 0;
        org = 0;
        k = 0;
        st = st_paused;
        b = '0;
        void'($urandom(32'ha0b));

        // reset must clear both outputs
        wait_cnt = 0;
        @(negedge clk_100mhz);
        while (rgb !== '0 || sprite_rom_addr !== '0) begin
            if (wait_cnt == 5) begin
                $display("timeout: rgb and sprite_rom_addr were not cleared by reset");
                stop_run();
            end
            @(negedge clk_100mhz);
            wait_cnt++;
        end
        repeat (3) begin
            @(negedge clk_100mhz);
            check_rgb(rgb, '0);
            check_addr(sprite_rom_addr, '0);
        end

        // segments of fixed status and bpm with two rounds of all four statuses first
        for (int seg = 0; seg < 24; seg++) begin
            st = (seg < 8) ? sys_status_t'(seg % 4) : sys_status_t'($urandom % 4);
            b = 8'($urandom % 256);
            hold = 6;
            for (int c = 0; c < 200; c++) begin
                if (c % 100 == 0) begin
                    org = (st == st_boot && (c == 0 || $urandom % 2 == 0)) ?
                          10 : int'($urandom % 10);
                    k = 0;
                end
                if ($urandom % 4 == 0) begin
                    px = int'($urandom % `HR_SCREEN_W);
                    py = int'($urandom % `HR_SCREEN_H);
                end else begin
                    px = sweep_x[org] + k % 64;
                    py = sweep_y[org] + (k / 64) * 3;
                    k++;
                end
                step(1'b1, px, py, st, b);
            end
        end

        // let the last pixels leave the pipeline
        wait_cnt = 0;
        while (rgb_q.size() > 0 || addr_q.size() > 0) begin
            if (wait_cnt == 10) begin
                $display("timeout: pixels still in the pipeline at the end of the run");
                stop_run();
            end
            step(1'b0, px, py, st, b);
            wait_cnt++;
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* pixel_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer (
    input  logic                        clk_100mhz,
    input  logic                        rst_n,
    input  hr_display_pkg::sprite_pix_t spr,
    input  hr_display_pkg::color_u      ovl_pix,
    input  logic                        rom_data,
    output hr_display_pkg::color_u      rgb
);
    import hr_display_pkg::*;

    sprite_pix_t spr_d;
    color_u      ovl_d;
    logic        lit;

    // rom answers one cycle after the address, so wait for it
    always_ff @(posedge clk_100mhz) begin
        if (!rst_n) begin
            spr_d.hit <= 1'b0;
        end else begin
            spr_d.hit <= spr.hit;
        end
        spr_d.color <= spr.color;
        ovl_d <= ovl_pix;
    end

    // a set sheet bit inside a sprite wins
    assign lit = spr_d.hit && rom_data;

    always_ff @(posedge clk_100mhz) begin
        if (!rst_n) begin
            rgb <= '0;
        end else begin
            rgb.rgb.r <= lit ? spr_d.color.rgb.r : ovl_d.rgb.r;
            rgb.rgb.g <= lit ? spr_d.color.rgb.g : ovl_d.rgb.g;
            rgb.rgb.b <= lit ? spr_d.color.rgb.b : ovl_d.rgb.b;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f hr_display.f --top-module hr_display_tb \
    -o hr_display_sim

run_status=0
./obj_dir/hr_display_sim > sim.log 2>&1 || run_status=$?
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
exit "$run_status"

/* shape_overlay.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hr_display_params.svh"

module shape_overlay (
    input  logic                          clk_100mhz,
    input  logic                          rst_n,
    input  logic [`HR_HCOUNT_W-1:0]       hcount,
    input  logic [`HR_VCOUNT_W-1:0]       vcount,
    input  hr_display_pkg::overlay_ctrl_t ovl,
    output hr_display_pkg::color_u        ovl_pix
);
    import hr_display_pkg::*;

    logic   top_hit;
    logic   bottom_hit;
    logic   error_hit;
    logic   progress_hit;
    color_u pix_next;

    always_comb begin
        top_hit = ovl.top_en && in_rect(hcount, vcount, `HR_TOP_BAR_X, `HR_TOP_BAR_Y,
                                        `HR_TOP_BAR_W, `HR_TOP_BAR_H);
        bottom_hit = ovl.bottom_en && in_rect(hcount, vcount, `HR_BOTTOM_BAR_X,
                                              `HR_BOTTOM_BAR_Y, `HR_BOTTOM_BAR_W,
                                              `HR_BOTTOM_BAR_H);
        error_hit = ovl.error_en && in_rect(hcount, vcount, `HR_ERROR_BOX_X,
                                            `HR_ERROR_BOX_Y, `HR_ERROR_BOX_W,
                                            `HR_ERROR_BOX_H);
        // bar grows from the left edge
        progress_hit = ovl.progress_en && in_rect(hcount, vcount, `HR_PROGRESS_X,
                                                  `HR_PROGRESS_Y, int'(ovl.progress_w),
                                                  `HR_PROGRESS_H);
    end

    // overlapping rectangles blend by or
    always_comb begin
        pix_next.raw = '0;
        if (top_hit) pix_next.raw = pix_next.raw | ovl.top_color.raw;
        if (bottom_hit) pix_next.raw = pix_next.raw | ovl.bottom_color.raw;
        if (error_hit) pix_next.raw = pix_next.raw | ovl.error_color.raw;
        if (progress_hit) pix_next.raw = pix_next.raw | `HR_COLOR_WHITE;
    end

    always_ff @(posedge clk_100mhz) begin
        if (!rst_n) begin
            ovl_pix <= '0;
        end else begin
            ovl_pix <= pix_next;
        end
    end

endmodule

`default_nettype wire

/* sprite_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hr_display_params.svh"

module sprite_addr_gen (
    input  logic                        clk_100mhz,
    input  logic                        rst_n,
    input  logic [`HR_HCOUNT_W-1:0]     hcount,
    input  logic [`HR_VCOUNT_W-1:0]     vcount,
    input  hr_display_pkg::sprite_en_t  spr_en,
    input  hr_display_pkg::bpm_bcd_t    digits,
    output hr_display_pkg::sprite_pix_t spr,
    output logic [`HR_ROM_ADDR_W-1:0]   rom_addr
);
    import hr_display_pkg::*;

    logic                      found;
    logic [`HR_ROM_ADDR_W-1:0] addr_next;
    color_u                    col_next;
    int                        px;
    int                        py;
    int                        hsx;
    int                        tsx;
    int                        osx;

    // first enabled sprite under the pixel wins
    function automatic void try_sprite(input logic en, input int px, input int py,
                                       input int x0, input int y0, input int sx, input int sy,
                                       input int w, input int h, input logic red,
                                       inout logic hit,
                                       inout logic [`HR_ROM_ADDR_W-1:0] addr,
                                       inout color_u col);
        if (!hit && en && in_rect(px, py, x0, y0, w, h)) begin
            hit = 1'b1;
            addr = `HR_ROM_ADDR_W'((sy + py - y0) * `HR_SHEET_W + sx + px - x0);
            col.raw = red ? `HR_COLOR_RED : `HR_COLOR_WHITE;
        end
    endfunction

    always_comb begin
        px = int'(hcount);
        py = int'(vcount);
        found = 1'b0;
        addr_next = '0;
        col_next.raw = '0;
        hsx = `HR_DIGIT_SX0 + int'(digits.hundreds) * `HR_DIGIT_PITCH;
        tsx = `HR_DIGIT_SX0 + int'(digits.tens) * `HR_DIGIT_PITCH;
        osx = `HR_DIGIT_SX0 + int'(digits.ones) * `HR_DIGIT_PITCH;
        try_sprite(spr_en.logo, px, py, `HR_LOGO_X, `HR_LOGO_Y, `HR_LOGO_SX, `HR_LOGO_SY,
                   `HR_LOGO_SW, `HR_LOGO_SH, 1'b1, found, addr_next, col_next);
        try_sprite(spr_en.collecting, px, py, `HR_COLLECT_X, `HR_COLLECT_Y, `HR_COLLECT_SX,
                   `HR_COLLECT_SY, `HR_COLLECT_SW, `HR_COLLECT_SH, 1'b0, found, addr_next,
                   col_next);
        try_sprite(spr_en.hundreds, px, py, `HR_HUNDREDS_X, `HR_HUNDREDS_Y, hsx, `HR_DIGIT_SY,
                   `HR_DIGIT_W, `HR_DIGIT_H, 1'b0, found, addr_next, col_next);
        try_sprite(spr_en.bpm_label, px, py, `HR_BPM_LABEL_X, `HR_BPM_LABEL_Y,
                   `HR_BPM_LABEL_SX, `HR_BPM_LABEL_SY, `HR_BPM_LABEL_SW, `HR_BPM_LABEL_SH,
                   1'b1, found, addr_next, col_next);
        try_sprite(spr_en.tens, px, py, `HR_TENS_X, `HR_TENS_Y, tsx, `HR_DIGIT_SY,
                   `HR_DIGIT_W, `HR_DIGIT_H, 1'b0, found, addr_next, col_next);
        try_sprite(spr_en.ones, px, py, `HR_ONES_X, `HR_ONES_Y, osx, `HR_DIGIT_SY,
                   `HR_DIGIT_W, `HR_DIGIT_H, 1'b0, found, addr_next, col_next);
        try_sprite(spr_en.title, px, py, `HR_TITLE_X, `HR_TITLE_Y, `HR_TITLE_SX, `HR_TITLE_SY,
                   `HR_TITLE_SW, `HR_TITLE_SH, 1'b1, found, addr_next, col_next);
        try_sprite(spr_en.error_txt, px, py, `HR_ERROR_TXT_X, `HR_ERROR_TXT_Y,
                   `HR_ERROR_TXT_SX, `HR_ERROR_TXT_SY, `HR_ERROR_TXT_SW, `HR_ERROR_TXT_SH,
                   1'b0, found, addr_next, col_next);
        try_sprite(spr_en.paused_txt, px, py, `HR_PAUSED_TXT_X, `HR_PAUSED_TXT_Y,
                   `HR_PAUSED_TXT_SX, `HR_PAUSED_TXT_SY, `HR_PAUSED_TXT_SW,
                   `HR_PAUSED_TXT_SH, 1'b0, found, addr_next, col_next);
        try_sprite(spr_en.boot_txt, px, py, `HR_BOOT_TXT_X, `HR_BOOT_TXT_Y, `HR_BOOT_TXT_SX,
                   `HR_BOOT_TXT_SY, `HR_BOOT_TXT_SW, `HR_BOOT_TXT_SH, 1'b0, found, addr_next,
                   col_next);
    end

    always_ff @(posedge clk_100mhz) begin
        if (!rst_n) begin
            rom_addr <= '0;
            spr <= '0;
        end else begin
            rom_addr <= addr_next;
            spr.hit <= found;
            spr.color <= col_next;
        end
    end

endmodule

`default_nettype wire

/* status_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hr_display_params.svh"

module status_decode (
    input  logic                          clk_100mhz,
    input  logic                          rst_n,
    input  hr_display_pkg::sys_status_t   status,
    input  logic [7:0]                    bpm,
    output hr_display_pkg::overlay_ctrl_t ovl,
    output hr_display_pkg::sprite_en_t    spr_en
);
    import hr_display_pkg::*;

    logic [`HR_PROGRESS_DIV_W-1:0] presc;
    logic [`HR_PROGRESS_DIV_W-1:0] presc_next;
    overlay_ctrl_t                 ovl_next;
    sprite_en_t                    en_next;

    //////////////////////////////////////////////////////////////////////
    // per-status overlay and sprite selection
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        ovl_next = '0;
        en_next = '0;
        presc_next = '0;
        en_next.logo = 1'b1;
        en_next.title = 1'b1;
        case (status)
            st_paused: begin
                ovl_next.top_en = 1'b1;
                ovl_next.bottom_en = 1'b1;
                ovl_next.top_color.raw = `HR_COLOR_GREY;
                ovl_next.bottom_color.raw = `HR_COLOR_GREY;
                en_next.paused_txt = 1'b1;
                en_next.bpm_label = 1'b1;
                en_next.tens = 1'b1;
                en_next.ones = 1'b1;
            end
            st_running: begin
                ovl_next.top_en = 1'b1;
                ovl_next.bottom_en = 1'b1;
                ovl_next.top_color.raw = `HR_COLOR_RED;
                ovl_next.bottom_color.raw = `HR_COLOR_BLUE;
                en_next.collecting = 1'b1;
                en_next.bpm_label = 1'b1;
                en_next.tens = 1'b1;
                en_next.ones = 1'b1;
                // leading digit only for three-digit rates
                en_next.hundreds = (bpm > 8'd99);
            end
            st_error: begin
                ovl_next.top_en = 1'b1;
                ovl_next.bottom_en = 1'b1;
                ovl_next.error_en = 1'b1;
                ovl_next.top_color.raw = `HR_COLOR_GREY;
                ovl_next.bottom_color.raw = `HR_COLOR_GREY;
                ovl_next.error_color.raw = `HR_COLOR_ALERT;
                en_next.error_txt = 1'b1;
            end
            st_boot: begin
                ovl_next.progress_en = 1'b1;
                en_next.boot_txt = 1'b1;
                presc_next = presc + 1'b1;
                // one pixel per prescaler wrap
                if (presc == '0 && ovl.progress_w < `HR_HCOUNT_W'(`HR_PROGRESS_MAX)) begin
                    ovl_next.progress_w = ovl.progress_w + 1'b1;
                end else begin
                    ovl_next.progress_w = ovl.progress_w;
                end
            end
        endcase
    end

    always_ff @(posedge clk_100mhz) begin
        if (!rst_n) begin
            ovl <= '0;
            spr_en <= '0;
            presc <= '0;
        end else begin
            ovl <= ovl_next;
            spr_en <= en_next;
            presc <= presc_next;
        end
    end

endmodule

`default_nettype wire
